/* rtl/cpuTypesPkg.sv */
package cpuTypesPkg;

  typedef logic [31:0] wordT;
  typedef logic [4:0]  regIdxT;

  // primary opcode field.
  typedef enum logic [5:0] {
    opRtype = 6'b000000,
    opJ     = 6'b000010,
    opJal   = 6'b000011,
    opBeq   = 6'b000100,
    opBne   = 6'b000101,
    opAddiu = 6'b001001,
    opSlti  = 6'b001010,
    opAndi  = 6'b001100,
    opOri   = 6'b001101,
    opLui   = 6'b001111,
    opLw    = 6'b100011,
    opSw    = 6'b101011
  } opcodeT;

  // r-type function field.
  typedef enum logic [5:0] {
    funcSll  = 6'b000000,
    funcJr   = 6'b001000,
    funcAddu = 6'b100001,
    funcSubu = 6'b100011,
    funcAnd  = 6'b100100,
    funcOr   = 6'b100101,
    funcSlt  = 6'b101010
  } funcT;

  typedef enum logic [3:0] {
    aluSll, aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui
  } aluOpT;

  typedef enum logic [1:0] {srcReg, srcImm, srcShamt} aluSrcT;

  typedef enum logic [1:0] {wbAlu, wbMem, wbPc4} wbSelT;

  typedef enum logic [1:0] {destRt, destRd, destRa} destSelT;

  typedef enum logic [1:0] {pcNext4, pcBranch, pcJump, pcReg} pcSelT;

  localparam wordT haltWord = 32'hffff_ffff; // halt encoding.

endpackage

/* rtl/programCounter.sv */
`timescale 1ns/10ps

module programCounter import cpuTypesPkg::*; #(
  parameter wordT pcInit = '0
) (
  input  logic        CLK,
  input  logic        reset,
  input  logic        advance,
  input  logic        haltInstr,
  input  logic        isBranch,
  input  logic        branchOnEqual,
  input  logic        aluZero,
  input  pcSelT       pcSel,
  input  wordT        immediate,
  input  logic [25:0] jumpField,
  input  wordT        regTarget,
  output wordT        pc,
  output wordT        pcPlus4,
  output logic        halt
);

  wordT nextPc;
  wordT branchTarget;
  logic takeBranch;

  assign pcPlus4      = pc + 32'd4;
  assign branchTarget = pcPlus4 + {immediate[29:0], 2'b00}; // word offset.
  // beq wants equal operands, bne wants them different.
  assign takeBranch   = isBranch && (aluZero == branchOnEqual);

  always_comb begin
    case (pcSel)
      pcBranch: nextPc = takeBranch ? branchTarget : pcPlus4;
      pcJump:   nextPc = {pc[31:28], jumpField, 2'b00};
      pcReg:    nextPc = regTarget;
      default:  nextPc = pcPlus4;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      pc   <= pcInit;
      halt <= 1'b0;
    end else if (advance && !halt) begin
      if (haltInstr)
        halt <= 1'b1; // pc stays on the halt word.
      else
        pc <= nextPc;
    end
  end

endmodule

/* rtl/controlUnit.sv */
`timescale 1ns/10ps

module controlUnit import cpuTypesPkg::*; (
  input  wordT    instr,
  output aluOpT   aluOp,
  output aluSrcT  aluSrc,
  output logic    extSigned,
  output logic    regWrite,
  output logic    memRead,
  output logic    memWrite,
  output logic    isBranch,
  output logic    branchOnEqual,
  output logic    haltInstr,
  output wbSelT   wbSel,
  output destSelT destSel,
  output pcSelT   pcSel
);

  opcodeT opcode;
  funcT   funct;

  assign opcode = opcodeT'(instr[31:26]);
  assign funct  = funcT'(instr[5:0]);

  always_comb begin
    // defaults describe a no-op.
    aluOp         = aluAdd;
    aluSrc        = srcReg;
    extSigned     = 1'b1;
    regWrite      = 1'b0;
    memRead       = 1'b0;
    memWrite      = 1'b0;
    isBranch      = 1'b0;
    branchOnEqual = 1'b0;
    haltInstr     = 1'b0;
    wbSel         = wbAlu;
    destSel       = destRt;
    pcSel         = pcNext4;

    if (instr == haltWord) begin
      haltInstr = 1'b1;
    end else begin
      case (opcode)
        opRtype: begin
          destSel  = destRd;
          regWrite = 1'b1;
          case (funct)
            funcSll: begin
              aluOp  = aluSll;
              aluSrc = srcShamt; // shamt goes to operand a.
            end
            funcJr: begin
              regWrite = 1'b0;
              pcSel    = pcReg;
            end
            funcAddu: aluOp = aluAdd;
            funcSubu: aluOp = aluSub;
            funcAnd:  aluOp = aluAnd;
            funcOr:   aluOp = aluOr;
            funcSlt:  aluOp = aluSlt;
            default:  regWrite = 1'b0;
          endcase
        end
        opJ: pcSel = pcJump;
        opJal: begin
          pcSel    = pcJump;
          regWrite = 1'b1;
          wbSel    = wbPc4;
          destSel  = destRa; // link register.
        end
        opBeq, opBne: begin
          aluOp         = aluSub;
          isBranch      = 1'b1;
          branchOnEqual = (opcode == opBeq);
          pcSel         = pcBranch;
        end
        opAddiu, opSlti, opAndi, opOri, opLui: begin
          aluSrc   = srcImm;
          regWrite = 1'b1;
          if (opcode == opSlti) aluOp = aluSlt;
          if (opcode == opAndi) aluOp = aluAnd;
          if (opcode == opOri)  aluOp = aluOr;
          if (opcode == opLui)  aluOp = aluLui;
          extSigned = (opcode == opAddiu) || (opcode == opSlti);
        end
        opLw: begin
          aluSrc   = srcImm;
          memRead  = 1'b1;
          regWrite = 1'b1;
          wbSel    = wbMem;
        end
        opSw: begin
          aluSrc   = srcImm;
          memWrite = 1'b1;
        end
        default: ;
      endcase
    end
  end

endmodule

/* rtl/registerFile.sv */
`timescale 1ns/10ps

module registerFile import cpuTypesPkg::*; (
  input  logic   CLK,
  input  logic   reset,
  input  logic   writeEnable,
  input  regIdxT readSel1,
  input  regIdxT readSel2,
  input  regIdxT writeSel,
  input  wordT   writeData,
  output wordT   readData1,
  output wordT   readData2
);

  wordT regs [32];

  always_ff @(posedge CLK) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && (writeSel != '0)) begin
      regs[writeSel] <= writeData; // r0 never written.
    end
  end

  // reads see the value before this cycle's write.
  assign readData1 = regs[readSel1];
  assign readData2 = regs[readSel2];

endmodule

/* rtl/alu.sv */
`timescale 1ns/10ps

module alu import cpuTypesPkg::*; (
  input  aluOpT aluOp,
  input  wordT  operandA,
  input  wordT  operandB,
  output wordT  result,
  output logic  zero,
  output logic  negative,
  output logic  overflow
);

  wordT sum;
  wordT diff;

  assign sum  = operandA + operandB;
  assign diff = operandA - operandB;

  always_comb begin
    case (aluOp)
      aluSll:  result = operandB << operandA[4:0];
      aluAdd:  result = sum;
      aluSub:  result = diff;
      aluAnd:  result = operandA & operandB;
      aluOr:   result = operandA | operandB;
      aluSlt:  result = {31'b0, $signed(operandA) < $signed(operandB)};
      aluLui:  result = {operandB[15:0], 16'b0};
      default: result = '0;
    endcase
  end

  assign zero     = (result == '0);
  assign negative = result[31];

  // signed overflow is reported only for add and sub.
  always_comb begin
    case (aluOp)
      aluAdd:  overflow = (operandA[31] == operandB[31]) && (sum[31] != operandA[31]);
      aluSub:  overflow = (operandA[31] != operandB[31]) && (diff[31] != operandA[31]);
      default: overflow = 1'b0;
    endcase
  end

endmodule

/* rtl/requestUnit.sv */
`timescale 1ns/10ps

module requestUnit (
  input  logic CLK,
  input  logic reset,
  input  logic memRead,
  input  logic memWrite,
  input  logic instrHit,
  input  logic dataHit,
  output logic dataRead,
  output logic dataWrite,
  output logic advance
);

  logic memInstr;
  logic pending;

  assign memInstr = memRead | memWrite;
  assign pending  = dataRead | dataWrite;

  // request levels rise the cycle after the fetch and hold until the hit.
  always_ff @(posedge CLK) begin
    if (reset) begin
      dataRead  <= 1'b0;
      dataWrite <= 1'b0;
    end else if (dataHit) begin
      dataRead  <= 1'b0;
      dataWrite <= 1'b0;
    end else if (instrHit && !pending) begin
      dataRead  <= memRead;
      dataWrite <= memWrite;
    end
  end

  // memory ops finish on the data hit, everything else on the fetch.
  assign advance = (instrHit && !memInstr) || dataHit;

endmodule

/* rtl/singleCycleCpu.sv */
`timescale 1ns/10ps

module singleCycleCpu import cpuTypesPkg::*; #(
  parameter wordT pcInit = '0
) (
  input  logic CLK,
  input  logic reset,
  input  logic instrHit,
  input  logic dataHit,
  input  wordT instrLoad,
  input  wordT dataLoad,
  output logic instrRead,
  output logic dataRead,
  output logic dataWrite,
  output logic halt,
  output wordT instrAddr,
  output wordT dataAddr,
  output wordT dataStore
);

  wordT    pc, pcPlus4;
  wordT    immExt;
  wordT    rsData, rtData;
  wordT    operandA, operandB;
  wordT    aluResult;
  wordT    writeData;
  regIdxT  writeSel;
  aluOpT   aluOp;
  aluSrcT  aluSrc;
  wbSelT   wbSel;
  destSelT destSel;
  pcSelT   pcSel;
  logic    extSigned, regWrite, memRead, memWrite;
  logic    isBranch, branchOnEqual, haltInstr;
  logic    aluZero, advance, regWriteEn;

  // immediate extender.
  assign immExt = extSigned ? {{16{instrLoad[15]}}, instrLoad[15:0]}
                            : {16'b0, instrLoad[15:0]};

  // sll takes the shift amount on port a.
  assign operandA = (aluSrc == srcShamt) ? {27'b0, instrLoad[10:6]} : rsData;
  assign operandB = (aluSrc == srcImm) ? immExt : rtData;

  always_comb begin
    case (wbSel)
      wbMem:   writeData = dataLoad;
      wbPc4:   writeData = pcPlus4;
      default: writeData = aluResult;
    endcase
  end

  always_comb begin
    case (destSel)
      destRd:  writeSel = instrLoad[15:11];
      destRa:  writeSel = 5'd31;
      default: writeSel = instrLoad[20:16];
    endcase
  end

  assign regWriteEn = regWrite && advance && !halt; // commit on advance only.

  programCounter #(.pcInit(pcInit)) pc_i (
    .CLK(CLK), .reset(reset), .advance(advance), .haltInstr(haltInstr),
    .isBranch(isBranch), .branchOnEqual(branchOnEqual), .aluZero(aluZero),
    .pcSel(pcSel), .immediate(immExt), .jumpField(instrLoad[25:0]),
    .regTarget(rsData), .pc(pc), .pcPlus4(pcPlus4), .halt(halt)
  );

  controlUnit control_i (
    .instr(instrLoad), .aluOp(aluOp), .aluSrc(aluSrc), .extSigned(extSigned),
    .regWrite(regWrite), .memRead(memRead), .memWrite(memWrite),
    .isBranch(isBranch), .branchOnEqual(branchOnEqual), .haltInstr(haltInstr),
    .wbSel(wbSel), .destSel(destSel), .pcSel(pcSel)
  );

  registerFile regFile_i (
    .CLK(CLK), .reset(reset), .writeEnable(regWriteEn),
    .readSel1(instrLoad[25:21]), .readSel2(instrLoad[20:16]),
    .writeSel(writeSel), .writeData(writeData),
    .readData1(rsData), .readData2(rtData)
  );

  alu alu_i (
    .aluOp(aluOp), .operandA(operandA), .operandB(operandB),
    .result(aluResult), .zero(aluZero), .negative(), .overflow()
  );

  requestUnit request_i (
    .CLK(CLK), .reset(reset), .memRead(memRead), .memWrite(memWrite),
    .instrHit(instrHit), .dataHit(dataHit), .dataRead(dataRead),
    .dataWrite(dataWrite), .advance(advance)
  );

  assign instrAddr = pc;
  assign instrRead = !halt;
  assign dataAddr  = aluResult;
  assign dataStore = rtData;

endmodule

/* dv/clockGen.sv */
`timescale 1ns/10ps

module clockGen #(
  parameter int periodNs    = 8,
  parameter int resetCycles = 16
) (
  output logic CLK,
  output logic reset
);

  initial CLK = 1'b0;
  always #(periodNs / 2) CLK = ~CLK;

  initial begin
    reset = 1'b1;
    repeat (resetCycles) @(posedge CLK);
    #1 reset = 1'b0; // released off the edge.
  end

endmodule

/* dv/cpuTb.sv */
`timescale 1ns/10ps

module cpuTb import cpuTypesPkg::*; ();

  localparam int progLen   = 39;
  localparam int numStores = 15;
  localparam int resetCyc  = 16;
  localparam int timeoutNs = resetCyc * 8 + progLen * 8 * 8 * 4;
  localparam wordT haltAddr = 32'h0000_0090; // word 36.

  logic CLK, reset;
  logic instrHit, dataHit, instrRead, dataRead, dataWrite, halt;
  wordT instrLoad, dataLoad, instrAddr, dataAddr, dataStore;

  wordT progWords [progLen];
  wordT imem [256];
  wordT dmem [256];
  wordT expAddr [numStores] = '{
    32'h100, 32'h104, 32'h108, 32'h10c, 32'h110, 32'h114, 32'h118, 32'h11c,
    32'h120, 32'h124, 32'h128, 32'h12c, 32'h130, 32'h134, 32'h138
  };
  wordT expData [numStores] = '{
    32'hffff_fffb, 32'h0000_8001, 32'h0000_f0f0, 32'h123c_0010, 32'h0000_8006,
    32'h1234_0000, 32'h1234_8001, 32'h0000_0001, 32'h0000_0000, 32'hcafe_f00d,
    32'h0000_0000, 32'hffff_fffb, 32'h0000_8001, 32'h1234_8001, 32'h0000_008c
  };
  int   storeIdx = 0;
  logic holding = 1'b0;
  wordT heldAddr, heldStore;

  clockGen #(.periodNs(8), .resetCycles(resetCyc)) clk_i (.CLK(CLK), .reset(reset));

  singleCycleCpu #(.pcInit(32'h0)) dut_i (
    .CLK(CLK), .reset(reset), .instrHit(instrHit), .dataHit(dataHit),
    .instrLoad(instrLoad), .dataLoad(dataLoad), .instrRead(instrRead),
    .dataRead(dataRead), .dataWrite(dataWrite), .halt(halt),
    .instrAddr(instrAddr), .dataAddr(dataAddr), .dataStore(dataStore)
  );

  function automatic wordT encodeR(regIdxT rs, regIdxT rt, regIdxT rd, logic [4:0] sh,
                                   funcT fn);
    return {6'b000000, rs, rt, rd, sh, fn};
  endfunction

  function automatic wordT encodeI(opcodeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic wordT encodeJ(opcodeT op, logic [25:0] target);
    return {op, target};
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkValue(input string what, input wordT got, input wordT exp);
    if (got !== exp) begin
      $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("=== FAIL ===");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic loadProgram();
    progWords[0]  = encodeI(opAddiu, 5'd0, 5'd1, 16'hfffb);
    progWords[1]  = encodeI(opSw, 5'd0, 5'd1, 16'h0100);
    progWords[2]  = encodeI(opOri, 5'd0, 5'd2, 16'h8001);  // zero extended.
    progWords[3]  = encodeI(opAndi, 5'd1, 5'd3, 16'hf0f0);
    progWords[4]  = encodeI(opSw, 5'd0, 5'd2, 16'h0104);
    progWords[5]  = encodeI(opSw, 5'd0, 5'd3, 16'h0108);
    progWords[6]  = encodeI(opLui, 5'd0, 5'd4, 16'h1234);
    progWords[7]  = encodeR(5'd0, 5'd2, 5'd5, 5'd4, funcSll);
    progWords[8]  = encodeR(5'd4, 5'd5, 5'd6, 5'd0, funcAddu);
    progWords[9]  = encodeR(5'd2, 5'd1, 5'd7, 5'd0, funcSubu);
    progWords[10] = encodeR(5'd1, 5'd4, 5'd8, 5'd0, funcAnd);
    progWords[11] = encodeR(5'd2, 5'd4, 5'd9, 5'd0, funcOr);
    progWords[12] = encodeR(5'd1, 5'd2, 5'd10, 5'd0, funcSlt); // -5 < 0x8001.
    progWords[13] = encodeI(opSlti, 5'd2, 5'd11, 16'hffff);
    progWords[14] = encodeI(opSw, 5'd0, 5'd6, 16'h010c);
    progWords[15] = encodeI(opSw, 5'd0, 5'd7, 16'h0110);
    progWords[16] = encodeI(opSw, 5'd0, 5'd8, 16'h0114);
    progWords[17] = encodeI(opSw, 5'd0, 5'd9, 16'h0118);
    progWords[18] = encodeI(opSw, 5'd0, 5'd10, 16'h011c);
    progWords[19] = encodeI(opSw, 5'd0, 5'd11, 16'h0120);
    progWords[20] = encodeI(opLw, 5'd0, 5'd12, 16'h0200);
    progWords[21] = encodeI(opSw, 5'd0, 5'd12, 16'h0124);
    progWords[22] = encodeI(opAddiu, 5'd0, 5'd0, 16'h0007); // r0 must stay zero.
    progWords[23] = encodeI(opSw, 5'd0, 5'd0, 16'h0128);
    progWords[24] = encodeI(opBeq, 5'd1, 5'd2, 16'h0001);
    progWords[25] = encodeI(opSw, 5'd0, 5'd1, 16'h012c);
    progWords[26] = encodeI(opBeq, 5'd10, 5'd10, 16'h0001);
    progWords[27] = encodeI(opSw, 5'd0, 5'd4, 16'h01fc); // skipped.
    progWords[28] = encodeI(opBne, 5'd1, 5'd1, 16'h0001);
    progWords[29] = encodeI(opSw, 5'd0, 5'd2, 16'h0130);
    progWords[30] = encodeI(opBne, 5'd1, 5'd2, 16'h0001);
    progWords[31] = encodeI(opSw, 5'd0, 5'd4, 16'h01fc); // skipped.
    progWords[32] = encodeJ(opJ, 26'd34);
    progWords[33] = encodeI(opSw, 5'd0, 5'd4, 16'h01fc); // skipped.
    progWords[34] = encodeJ(opJal, 26'd37);
    progWords[35] = encodeI(opSw, 5'd0, 5'd31, 16'h0138);
    progWords[36] = haltWord;
    progWords[37] = encodeI(opSw, 5'd0, 5'd9, 16'h0134);
    progWords[38] = encodeR(5'd31, 5'd0, 5'd0, 5'd0, funcJr);
    for (int i = 0; i < 256; i++) begin
      imem[i] = (i < progLen) ? progWords[i] : haltWord;
      dmem[i] = 32'ha5a5_0000 ^ (i << 2) ^ (i << 20); // address dependent fill.
    end
    dmem[8'h80] = 32'hcafe_f00d; // byte address 0x200.
  endtask

  // memory models drive 1 ns after the rising edge.
  initial begin
    int unsigned instrWait;
    int unsigned dataWait;
    logic dataBusy;
    logic inReset;
    wordT fetchAddr;
    instrHit  = 1'b0;
    dataHit   = 1'b0;
    instrLoad = '0;
    dataLoad  = '0;
    instrWait = 0;
    dataWait  = 0;
    dataBusy  = 1'b0;
    inReset   = 1'b1;
    fetchAddr = '1;
    void'($urandom(32'h51aa15a4));
    forever begin
      @(posedge CLK);
      inReset = reset; // the level the DUT saw at this edge.
      #1;
      if (inReset) begin
        instrHit  = 1'b0;
        dataHit   = 1'b0;
        dataBusy  = 1'b0;
        fetchAddr = '1;
      end else begin
        if (instrAddr !== fetchAddr) begin
          fetchAddr = instrAddr;
          instrWait = $urandom % 4; // fresh wait for a new fetch.
        end else if (instrWait > 0) begin
          instrWait--;
        end
        instrHit  = instrRead && (instrWait == 0);
        instrLoad = instrHit ? imem[fetchAddr[9:2]] : '0;
        if (dataHit) begin
          dataHit  = 1'b0; // request drops after its hit.
          dataBusy = 1'b0;
        end else if (dataRead || dataWrite) begin
          if (!dataBusy) begin
            dataBusy = 1'b1;
            dataWait = $urandom % 4;
          end else if (dataWait > 0) begin
            dataWait--;
          end
          dataHit  = (dataWait == 0);
          dataLoad = dmem[dataAddr[9:2]];
        end
      end
    end
  end

  // store checks and request stability are sampled mid cycle.
  always @(negedge CLK) begin
    if (!reset) begin
      if (dataRead || dataWrite) begin
        if (holding) begin
          checkValue("held dataAddr", dataAddr, heldAddr);
          checkValue("held dataStore", dataStore, heldStore);
        end else begin
          heldAddr  = dataAddr;
          heldStore = dataStore;
          holding   = 1'b1;
        end
      end else begin
        holding = 1'b0;
      end
      if (dataHit && dataWrite) begin
        if (storeIdx >= numStores) begin
          failRun($sformatf("unexpected store to address %h", dataAddr));
        end else begin
          checkValue("store address", dataAddr, expAddr[storeIdx]);
          checkValue("store data", dataStore, expData[storeIdx]);
          storeIdx++;
          dmem[dataAddr[9:2]] = dataStore;
        end
      end
    end
  end

  initial begin
    #(timeoutNs);
    failRun("timeout: the program did not finish in time");
  end

  initial begin
    loadProgram();
    @(negedge reset);
    @(negedge CLK);
    checkValue("instrAddr after reset", instrAddr, 32'h0);
    checkValue("dataRead after reset", {31'b0, dataRead}, 32'h0);
    checkValue("dataWrite after reset", {31'b0, dataWrite}, 32'h0);
    checkValue("halt after reset", {31'b0, halt}, 32'h0);
    checkValue("instrRead after reset", {31'b0, instrRead}, 32'h1);
    wait (storeIdx == numStores);
    wait (halt);
    repeat (4) begin
      @(negedge CLK);
      checkValue("instrAddr while halted", instrAddr, haltAddr);
      checkValue("halt level", {31'b0, halt}, 32'h1);
    end
    $display("=== PASS ===");
    $finish;
  end

endmodule

/* sources.f */
rtl/cpuTypesPkg.sv
rtl/programCounter.sv
rtl/controlUnit.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/requestUnit.sv
rtl/singleCycleCpu.sv
dv/clockGen.sv
dv/cpuTb.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing -j 0
TOP      := cpuTb
FILELIST := sources.f
OBJDIR   := obj_dir
PASSMSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run the simulation"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
